//--- src/div_pkg.sv
package div_pkg;

    // operand and result width of the execute stage.
    localparam int XLEN = 64;

    // width of the 32-bit W operations.
    localparam int WLEN = 32;

    localparam int TAG_W = 4;

    // number of divider lanes, 1 to 8 are supported.
    localparam int NUM_LANES = 4;

    // lane index needs at least one bit even with a single lane.
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // one quotient bit per iteration cycle.
    localparam int ITER_STEPS = 64;
    localparam int ITER_CNT_W = $clog2(ITER_STEPS);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;
    typedef logic [NUM_LANES-1:0]  lane_mask_t;

    // already decoded M-extension divide operations.
    typedef enum logic [2:0] {
        OP_DIV   = 3'd0,
        OP_DIVU  = 3'd1,
        OP_REM   = 3'd2,
        OP_REMU  = 3'd3,
        OP_DIVW  = 3'd4,
        OP_DIVUW = 3'd5,
        OP_REMW  = 3'd6,
        OP_REMUW = 3'd7
    } div_op_t;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_PREP = 2'd1,
        LANE_ITER = 2'd2,
        LANE_DONE = 2'd3
    } lane_state_t;

endpackage

//--- src/div_dispatch.sv
`timescale 1ns/10ps

module div_dispatch (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  div_pkg::div_op_t    req_op,
    input  div_pkg::xlen_t      req_dividend,
    input  div_pkg::xlen_t      req_divisor,
    input  div_pkg::tag_t       req_tag,
    input  div_pkg::lane_mask_t lane_idle,
    output logic                busy,
    output div_pkg::lane_mask_t lane_start,
    output div_pkg::div_op_t    issue_op,
    output div_pkg::xlen_t      issue_dividend,
    output div_pkg::xlen_t      issue_divisor,
    output div_pkg::tag_t       issue_tag
);
    import div_pkg::*;

    logic       pending;
    logic       any_idle;
    logic       accept;
    logic       issue;
    lane_mask_t first_idle;

    // priority select of the lowest-numbered idle lane.
    always_comb begin
        first_idle = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lane_idle[i]) begin
                first_idle    = '0;
                first_idle[i] = 1'b1;
            end
        end
    end

    assign any_idle = |lane_idle;

    // a held request blocks the input until a lane takes it.
    assign busy   = pending || !any_idle;
    assign accept = req_valid && !busy;
    assign issue  = pending && any_idle;

    assign lane_start = issue ? first_idle : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (issue) begin
            pending <= 1'b0;
        end
    end

    // broadcast registers, the started lane copies them on its start edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_op       <= req_op;
            issue_dividend <= req_dividend;
            issue_divisor  <= req_divisor;
            issue_tag      <= req_tag;
        end
    end

endmodule

//--- src/div_lane.sv
`timescale 1ns/10ps

module div_lane (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    input  div_pkg::tag_t    tag,
    input  logic             ack,
    output logic             idle,
    output logic             done,
    output div_pkg::xlen_t   result,
    output div_pkg::tag_t    result_tag
);
    import div_pkg::*;

    lane_state_t state;
    logic [ITER_CNT_W-1:0] iter_cnt;

    // request copied on start.
    div_op_t op_q;
    tag_t    tag_q;
    xlen_t   dvd_raw;
    xlen_t   dvs_raw;

    // operand preparation.
    logic  is_w;
    logic  is_signed;
    logic  is_rem;
    xlen_t dvd_ext;
    xlen_t dvs_ext;
    xlen_t dvd_mag;
    xlen_t dvs_mag;
    xlen_t min_val;
    logic  dvd_neg;
    logic  dvs_neg;

    // iteration state, remainder in the upper half and quotient in the lower.
    logic [2*XLEN-1:0] rq;
    logic [XLEN:0]     dvs_r;
    logic              q_neg;
    logic              r_neg;
    logic              div_zero;
    logic              overflow;
    xlen_t             dvd_keep;

    logic [2*XLEN:0]   shifted;
    logic [XLEN:0]     partial;
    xlen_t             diff;
    logic [2*XLEN-1:0] step_rq;

    xlen_t quo_fix;
    xlen_t rem_fix;
    xlen_t sel;
    xlen_t res_final;

    assign is_w      = op_q inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    assign is_signed = op_q inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
    assign is_rem    = op_q inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};

    always_comb begin
        if (is_w && is_signed) begin
            dvd_ext = {{(XLEN-WLEN){dvd_raw[WLEN-1]}}, dvd_raw[WLEN-1:0]};
            dvs_ext = {{(XLEN-WLEN){dvs_raw[WLEN-1]}}, dvs_raw[WLEN-1:0]};
            min_val = {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}};
        end else if (is_w) begin
            dvd_ext = {{(XLEN-WLEN){1'b0}}, dvd_raw[WLEN-1:0]};
            dvs_ext = {{(XLEN-WLEN){1'b0}}, dvs_raw[WLEN-1:0]};
            min_val = {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}};
        end else begin
            dvd_ext = dvd_raw;
            dvs_ext = dvs_raw;
            min_val = {1'b1, {(XLEN-1){1'b0}}};
        end
        dvd_neg = is_signed && dvd_ext[XLEN-1];
        dvs_neg = is_signed && dvs_ext[XLEN-1];
        dvd_mag = dvd_neg ? -dvd_ext : dvd_ext;
        dvs_mag = dvs_neg ? -dvs_ext : dvs_ext;
    end

    // one restoring shift-subtract step.
    always_comb begin
        shifted = {rq, 1'b0};
        partial = shifted[2*XLEN:XLEN];
        diff    = partial[XLEN-1:0] - dvs_r[XLEN-1:0];
        if (partial >= dvs_r) begin
            step_rq = {diff, shifted[XLEN-1:1], 1'b1};
        end else begin
            step_rq = shifted[2*XLEN-1:0];
        end
    end

    // sign fix-up and RISC-V corner results on the final step.
    always_comb begin
        quo_fix = q_neg ? -step_rq[XLEN-1:0] : step_rq[XLEN-1:0];
        rem_fix = r_neg ? -step_rq[2*XLEN-1:XLEN] : step_rq[2*XLEN-1:XLEN];
        if (div_zero) begin
            quo_fix = '1;
            rem_fix = dvd_keep;
        end else if (overflow) begin
            quo_fix = dvd_keep;
            rem_fix = '0;
        end
        sel = is_rem ? rem_fix : quo_fix;
        if (is_w) begin
            res_final = {{(XLEN-WLEN){sel[WLEN-1]}}, sel[WLEN-1:0]};
        end else begin
            res_final = sel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= LANE_IDLE;
            iter_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        state <= LANE_PREP;
                    end
                end
                LANE_PREP: begin
                    state    <= LANE_ITER;
                    iter_cnt <= '0;
                end
                LANE_ITER: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == ITER_CNT_W'(ITER_STEPS - 1)) begin
                        state <= LANE_DONE;
                    end
                end
                LANE_DONE: begin
                    if (ack) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && start) begin
            op_q    <= op;
            tag_q   <= tag;
            dvd_raw <= dividend;
            dvs_raw <= divisor;
        end
        if (state == LANE_PREP) begin
            rq       <= {{XLEN{1'b0}}, dvd_mag};
            dvs_r    <= {1'b0, dvs_mag};
            q_neg    <= dvd_neg ^ dvs_neg;
            r_neg    <= dvd_neg;
            div_zero <= (dvs_ext == '0);
            overflow <= is_signed && (dvd_ext == min_val) && (dvs_ext == '1);
            dvd_keep <= dvd_ext;
        end
        if (state == LANE_ITER) begin
            rq <= step_rq;
            if (iter_cnt == ITER_CNT_W'(ITER_STEPS - 1)) begin
                result <= res_final;
            end
        end
    end

    assign idle       = (state == LANE_IDLE);
    assign done       = (state == LANE_DONE);
    assign result_tag = tag_q;

endmodule

//--- src/div_collect.sv
`timescale 1ns/10ps

module div_collect (
    input  logic                clk,
    input  logic                reset,
    input  div_pkg::lane_mask_t lane_done,
    input  div_pkg::xlen_t      lane_result [div_pkg::NUM_LANES],
    input  div_pkg::tag_t       lane_tag [div_pkg::NUM_LANES],
    output div_pkg::lane_mask_t lane_ack,
    output logic                out_valid,
    output div_pkg::xlen_t      out_data,
    output div_pkg::tag_t       out_tag
);
    import div_pkg::*;

    lane_idx_t rr_ptr;
    lane_idx_t pick;
    lane_idx_t pick_next;
    logic      found;

    // first finished lane at or after the round-robin pointer.
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = rr_ptr;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = int'(rr_ptr) + k;
            if (cand >= NUM_LANES) begin
                cand = cand - NUM_LANES;
            end
            if (!found && lane_done[cand]) begin
                found = 1'b1;
                pick  = lane_idx_t'(cand);
            end
        end
    end

    always_comb begin
        if (pick == lane_idx_t'(NUM_LANES - 1)) begin
            pick_next = '0;
        end else begin
            pick_next = pick + 1'b1;
        end
    end

    // the lane sees its ack on the same edge its result is registered.
    assign lane_ack = found ? (lane_mask_t'(1) << pick) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= found;
            if (found) begin
                rr_ptr <= pick_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            out_data <= lane_result[pick];
            out_tag  <= lane_tag[pick];
        end
    end

endmodule

//--- src/div_unit_top.sv
`timescale 1ns/10ps

module div_unit_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             req_valid,
    input  div_pkg::div_op_t req_op,
    input  div_pkg::xlen_t   req_dividend,
    input  div_pkg::xlen_t   req_divisor,
    input  div_pkg::tag_t    req_tag,
    output logic             busy,
    output logic             out_valid,
    output div_pkg::xlen_t   out_data,
    output div_pkg::tag_t    out_tag
);
    import div_pkg::*;

    lane_mask_t lane_idle;
    lane_mask_t lane_start;
    lane_mask_t lane_done;
    lane_mask_t lane_ack;

    div_op_t issue_op;
    xlen_t   issue_dividend;
    xlen_t   issue_divisor;
    tag_t    issue_tag;

    xlen_t lane_result [NUM_LANES];
    tag_t  lane_tag [NUM_LANES];

    div_dispatch div_dispatch_inst (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_dividend   (req_dividend),
        .req_divisor    (req_divisor),
        .req_tag        (req_tag),
        .lane_idle      (lane_idle),
        .busy           (busy),
        .lane_start     (lane_start),
        .issue_op       (issue_op),
        .issue_dividend (issue_dividend),
        .issue_divisor  (issue_divisor),
        .issue_tag      (issue_tag)
    );

    // all lanes share the broadcast operands and differ only in start and ack.
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        div_lane div_lane_inst (
            .clk        (clk),
            .reset      (reset),
            .start      (lane_start[g]),
            .op         (issue_op),
            .dividend   (issue_dividend),
            .divisor    (issue_divisor),
            .tag        (issue_tag),
            .ack        (lane_ack[g]),
            .idle       (lane_idle[g]),
            .done       (lane_done[g]),
            .result     (lane_result[g]),
            .result_tag (lane_tag[g])
        );
    end

    div_collect div_collect_inst (
        .clk         (clk),
        .reset       (reset),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .lane_tag    (lane_tag),
        .lane_ack    (lane_ack),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_tag     (out_tag)
    );

endmodule

//--- test/div_unit_tb.sv
`timescale 1ns/10ps

module div_unit_tb;
    import div_pkg::*;

    localparam int    WAIT_LIMIT  = 2000;
    localparam int    DRAIN_LIMIT = 5000;
    localparam int    NUM_TAGS    = 2**TAG_W;
    localparam xlen_t MIN64       = {1'b1, 63'd0};
    localparam xlen_t MIN32_SEXT  = 64'hffff_ffff_8000_0000;

    logic    clk;
    logic    reset;
    logic    req_valid;
    div_op_t req_op;
    xlen_t   req_dividend;
    xlen_t   req_divisor;
    tag_t    req_tag;
    logic    busy;
    logic    out_valid;
    xlen_t   out_data;
    tag_t    out_tag;

    int      seed = 12489;
    xlen_t   exp_val [NUM_TAGS];
    div_op_t exp_op [NUM_TAGS];
    int      sent_cnt [NUM_TAGS] = '{default: 0};
    int      recv_cnt [NUM_TAGS] = '{default: 0};
    int      n_sent = 0;
    int      n_recv = 0;
    int      check_errs = 0;
    int      main_errs = 0;
    int      busy_run = 0;
    logic    full_seen = 1'b0;
    tag_t    next_tag = '0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    div_unit_top div_unit_top_inst (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .req_tag      (req_tag),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_tag      (out_tag)
    );

    // expected result by the RISC-V M-extension rules.
    // W ops divide the low words and sign-extend the 32-bit result.
    function automatic xlen_t ref_div(input div_op_t op, input xlen_t a, input xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [31:0]        ua;
        logic [31:0]        ub;
        logic [31:0]        r32;
        xlen_t              r;
        sa  = a;
        sb  = b;
        wa  = a[31:0];
        wb  = b[31:0];
        ua  = a[31:0];
        ub  = b[31:0];
        r   = '0;
        r32 = '0;
        case (op)
            OP_DIV, OP_REM: begin
                if (b == '0) begin
                    r = (op == OP_DIV) ? '1 : a;
                end else if (a == MIN64 && b == '1) begin
                    r = (op == OP_DIV) ? a : '0;
                end else if (op == OP_DIV) begin
                    r = sa / sb;
                end else begin
                    r = sa % sb;
                end
            end
            OP_DIVU:  r = (b == 0) ? '1 : a / b;
            OP_REMU:  r = (b == 0) ? a : a % b;
            OP_DIVW, OP_REMW: begin
                if (ub == '0) begin
                    r32 = (op == OP_DIVW) ? '1 : ua;
                end else if (ua == 32'h8000_0000 && ub == '1) begin
                    r32 = (op == OP_DIVW) ? ua : '0;
                end else if (op == OP_DIVW) begin
                    r32 = wa / wb;
                end else begin
                    r32 = wa % wb;
                end
            end
            OP_DIVUW: r32 = (ub == 0) ? '1 : ua / ub;
            OP_REMUW: r32 = (ub == 0) ? ua : ua % ub;
            default:  r = '0;
        endcase
        if (op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
            r = {{32{r32[31]}}, r32};
        end
        return r;
    endfunction

    function automatic xlen_t full_rand();
        return {$random(seed), $random(seed)};
    endfunction

    // random value with a random number of leading zeros.
    function automatic xlen_t scaled_rand();
        int sh;
        sh = $unsigned($random(seed)) % 64;
        return full_rand() >> sh;
    endfunction

    function automatic xlen_t directed_val(input int i);
        case (i)
            0:       return '0;
            1:       return 64'd1;
            2:       return '1;
            3:       return MIN64;
            default: return MIN32_SEXT;
        endcase
    endfunction

    task automatic send_req(input div_op_t op, input xlen_t a, input xlen_t b);
        int   waited;
        tag_t t;
        t = next_tag;
        waited = 0;
        while (sent_cnt[t] != recv_cnt[t] && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (sent_cnt[t] != recv_cnt[t]) begin
            $display("timeout waiting for tag %0d to come back, request dropped", t);
            main_errs++;
            return;
        end
        waited = 0;
        while (busy && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            $display("timeout waiting for busy to go low, request dropped");
            main_errs++;
            return;
        end
        exp_val[t] = ref_div(op, a, b);
        exp_op[t]  = op;
        sent_cnt[t]++;
        n_sent++;
        req_valid    = 1'b1;
        req_op       = op;
        req_dividend = a;
        req_divisor  = b;
        req_tag      = t;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        next_tag  = t + 1'b1;
    endtask

    task automatic unsigned_sweep();
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                send_req(OP_DIVU, directed_val(i), directed_val(j));
                send_req(OP_REMU, directed_val(i), directed_val(j));
            end
        end
        repeat (12) begin
            send_req(OP_DIVU, full_rand(), scaled_rand());
            send_req(OP_REMU, full_rand(), scaled_rand());
        end
    endtask

    task automatic signed_sweep();
        xlen_t a;
        xlen_t b;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                send_req(OP_DIV, directed_val(i), directed_val(j));
                send_req(OP_REM, directed_val(i), directed_val(j));
            end
        end
        // bit 0 makes the dividend negative, bit 1 the divisor.
        for (int s = 0; s < 4; s++) begin
            repeat (4) begin
                a = full_rand();
                b = scaled_rand();
                a[63] = 1'b0;
                b[63] = 1'b0;
                a = s[0] ? -a : a;
                b = s[1] ? -b : b;
                send_req(OP_DIV, a, b);
                send_req(OP_REM, a, b);
            end
        end
    endtask

    task automatic word_sweep();
        xlen_t   lo_a;
        xlen_t   lo_b;
        div_op_t op;
        for (int k = 4; k < 8; k++) begin
            op = div_op_t'(k);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    lo_a = directed_val(i);
                    lo_b = directed_val(j);
                    send_req(op, {$random(seed), lo_a[31:0]}, {$random(seed), lo_b[31:0]});
                end
            end
            repeat (6) begin
                lo_b = scaled_rand();
                send_req(op, full_rand(), {$random(seed), lo_b[31:0]});
            end
        end
    endtask

    task automatic corner_cases();
        for (int k = 0; k < 8; k++) begin
            send_req(div_op_t'(k), full_rand(), '0);
        end
        // W ops must ignore a nonzero upper divisor word.
        for (int k = 4; k < 8; k++) begin
            send_req(div_op_t'(k), full_rand(), {$random(seed), 32'd0});
        end
        send_req(OP_DIV, MIN64, '1);
        send_req(OP_REM, MIN64, '1);
        send_req(OP_DIVW, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff});
        send_req(OP_REMW, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff});
    endtask

    task automatic random_mix();
        repeat (64) begin
            send_req(div_op_t'($unsigned($random(seed)) % 8), full_rand(), scaled_rand());
        end
    endtask

    task automatic drain_and_audit();
        int waited;
        waited = 0;
        while (n_recv != n_sent && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (n_recv != n_sent) begin
            $display("timeout waiting for results, %0d sent and %0d returned", n_sent, n_recv);
            main_errs++;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (sent_cnt[t] != recv_cnt[t]) begin
                $display("tag %0d was sent %0d times and returned %0d times",
                         t, sent_cnt[t], recv_cnt[t]);
                main_errs++;
            end
        end
        if (!full_seen) begin
            $display("busy never stayed high with all lanes occupied");
            main_errs++;
        end
    endtask

    // results are checked at the falling edge where the outputs are stable.
    always @(negedge clk) begin
        div_op_t op_seen;
        if (!reset) begin
            // busy for two cycles in a row means no lane was idle.
            if (busy) begin
                busy_run++;
                if (busy_run >= 2) begin
                    full_seen = 1'b1;
                end
            end else begin
                busy_run = 0;
            end
            if (out_valid) begin
                op_seen = exp_op[out_tag];
                if (sent_cnt[out_tag] == 0) begin
                    $display("tag %0d came back but was never sent", out_tag);
                    check_errs++;
                end else if (recv_cnt[out_tag] >= sent_cnt[out_tag]) begin
                    $display("tag %0d came back more often than it was sent", out_tag);
                    check_errs++;
                end else begin
                    assert (out_data === exp_val[out_tag]) else begin
                        $display("ERR %0t: tag %0d %s returned %h, expected %h", $time,
                                 out_tag, op_seen.name(), out_data, exp_val[out_tag]);
                        check_errs++;
                    end
                    recv_cnt[out_tag]++;
                    n_recv++;
                end
            end
        end
    end

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = OP_DIV;
        req_dividend = '0;
        req_divisor  = '0;
        req_tag      = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (6) begin
            @(negedge clk);
            assert (!busy && !out_valid) else begin
                $display("ERR %0t: busy or out_valid high before the first request", $time);
                main_errs++;
            end
        end
        @(posedge clk);
        #1;
        unsigned_sweep();
        signed_sweep();
        word_sweep();
        corner_cases();
        random_mix();
        drain_and_audit();
        $display("checker errors: %0d, sequence errors: %0d", check_errs, main_errs);
        if (check_errs == 0 && main_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- div_unit.f
src/div_pkg.sv
src/div_dispatch.sv
src/div_lane.sv
src/div_collect.sv
src/div_unit_top.sv
test/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f div_unit.f --top-module div_unit_tb -o div_unit_sim

./obj_dir/div_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
